// ==== Makefile ====
# Verilator build and run for the serial bus master testbench

VERILATOR ?= verilator
TOP       ?= tb_bus_master
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
EXE       := $(BUILD_DIR)/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(EXE) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/bus_master_pkg.sv ====
// --------------------
// shared definitions for the serial bus master
// sequencer states, acknowledge patterns and default widths
// import with a wildcard in the module header
// --------------------

package bus_master_pkg;

    // sequencer states in 4 bits
    typedef enum logic [3:0]
    {
        IDLE            = 4'd0,
        BUS_REQUESTED   = 4'd1,
        BUS_GRANTED     = 4'd2,
        ADDRESS_SEND    = 4'd3,
        ADDR_ACK_WAIT   = 4'd4,
        ADDR_RETRY      = 4'd5,
        READ_START_WAIT = 4'd6,
        READ_DATA       = 4'd7,
        WRITE_DATA      = 4'd8,
        DATA_ACK_WAIT   = 4'd9
    } master_state_e;

    // two successive bus bits with the older bit in the msb
    localparam logic [1:0] ADDR_ACK_PATTERN = 2'b00;    // slave took the address
    localparam logic [1:0] DATA_ACK_PATTERN = 2'b01;    // write ack or read start marker

    // defaults for the top level parameters
    localparam int DEFAULT_DATA_WIDTH   = 8;
    localparam int DEFAULT_ADDR_WIDTH   = 15;
    localparam int DEFAULT_TIMEOUT_BITS = 6;           // msb releases the bus and all ones retries

endpackage

// ==== design/bit_deserializer.sv ====
// --------------------
// serial to parallel receiver for read data
// rx_start arms it and the bus is then sampled on DATA_WIDTH edges
// msb first from the edge that sees rx_start high
// rx_valid pulses one cycle after the last sample
// --------------------

module bit_deserializer
    import bus_master_pkg::*;
#(
    parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH
)
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  rx_start,
    input  logic                  b_bus_in,
    output logic [DATA_WIDTH-1:0] rx_data,
    output logic                  rx_valid
);

    localparam int CNT_W = $clog2(DATA_WIDTH + 1);

    logic [CNT_W-1:0] bit_cnt;      // samples still expected after this one
    logic             sampling;
    logic             last_sample;

    assign sampling    = rx_start || (bit_cnt != '0);
    assign last_sample = !rx_start && (bit_cnt == CNT_W'(1));

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end
        else
        begin
            rx_valid <= last_sample;
            if (rx_start)
                bit_cnt <= CNT_W'(DATA_WIDTH - 1);  // first sample taken right now
            else if (bit_cnt != '0)
                bit_cnt <= bit_cnt - 1'b1;
        end
    end

    // word assembles in place and holds after the last sample
    always_ff @(posedge clk)
    begin
        if (sampling)
            rx_data <= {rx_data[DATA_WIDTH-2:0], b_bus_in};
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rstn)
        rx_valid |=> !rx_valid);

endmodule

// ==== design/bit_serializer.sv ====
// --------------------
// parallel to serial shifter for the bus line
// a left aligned frame loads on tx_start and leaves msb first
// one bit per clock with tx_done in the last driven cycle
// --------------------

module bit_serializer
    import bus_master_pkg::*;
#(
    parameter int WIDTH = DEFAULT_ADDR_WIDTH
)
(
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       tx_start,
    input  logic [WIDTH-1:0]           tx_frame,
    input  logic [$clog2(WIDTH+1)-1:0] tx_len,
    output logic                       b_bus_out,
    output logic                       b_bus_drive,
    output logic                       tx_done
);

    localparam int LEN_W = $clog2(WIDTH + 1);

    logic [LEN_W-1:0] bit_cnt;      // bits still to go out
    logic [WIDTH-1:0] shreg;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            bit_cnt <= '0;
        end
        else if (tx_start)
        begin
            bit_cnt <= tx_len;
        end
        else if (bit_cnt != '0)
        begin
            bit_cnt <= bit_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (tx_start)
            shreg <= tx_frame;
        else if (bit_cnt != '0)
            shreg <= {shreg[WIDTH-2:0], 1'b0};    // next bit moves up to the msb
    end

    assign b_bus_out   = shreg[WIDTH-1];
    assign b_bus_drive = (bit_cnt != '0);
    assign tx_done     = (bit_cnt == LEN_W'(1));

    // the sequencer must let a frame finish before loading the next one
    a_no_restart: assert property (@(posedge clk) disable iff (!rstn)
        tx_start |-> (bit_cnt == '0));

endmodule

// ==== design/bus_master_top.sv ====
// --------------------
// serial bus master top level
// the FSM drives a serializer for outgoing frames and a
// deserializer for read data, both sharing the single bus line
// --------------------

module bus_master_top
    import bus_master_pkg::*;
#(
    parameter int DATA_WIDTH   = DEFAULT_DATA_WIDTH,
    parameter int ADDR_WIDTH   = DEFAULT_ADDR_WIDTH,
    parameter int TIMEOUT_BITS = DEFAULT_TIMEOUT_BITS
)
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  m_hold,
    input  logic                  m_execute,
    input  logic                  m_rw,         // 1 = write
    input  logic [ADDR_WIDTH-1:0] m_address,
    input  logic [DATA_WIDTH-1:0] m_din,
    output logic [DATA_WIDTH-1:0] m_dout,
    output logic                  m_dvalid,
    output logic                  m_master_bsy,
    input  logic                  b_grant,
    input  logic                  b_bus_in,     // idle line reads as 1
    output logic                  b_request,
    output logic                  b_rw,
    output logic                  b_busy,
    output logic                  b_bus_out,
    output logic                  b_bus_drive
);

    localparam int LEN_W = $clog2(ADDR_WIDTH + 1);

    logic                  tx_start;
    logic [ADDR_WIDTH-1:0] tx_frame;
    logic [LEN_W-1:0]      tx_len;
    logic                  tx_done;
    logic                  rx_start;
    logic                  rx_valid;
    logic [DATA_WIDTH-1:0] rx_data;

    master_sequencer #(
        .DATA_WIDTH   (DATA_WIDTH),
        .ADDR_WIDTH   (ADDR_WIDTH),
        .TIMEOUT_BITS (TIMEOUT_BITS)
    ) u_sequencer (
        .clk          (clk),
        .rstn         (rstn),
        .m_hold       (m_hold),
        .m_execute    (m_execute),
        .m_rw         (m_rw),
        .m_address    (m_address),
        .m_din        (m_din),
        .b_grant      (b_grant),
        .b_bus_in     (b_bus_in),
        .tx_done      (tx_done),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data),
        .m_dout       (m_dout),
        .m_dvalid     (m_dvalid),
        .m_master_bsy (m_master_bsy),
        .b_request    (b_request),
        .b_rw         (b_rw),
        .b_busy       (b_busy),
        .tx_start     (tx_start),
        .tx_frame     (tx_frame),
        .tx_len       (tx_len),
        .rx_start     (rx_start)
    );

    bit_serializer #(
        .WIDTH       (ADDR_WIDTH)
    ) u_serializer (
        .clk         (clk),
        .rstn        (rstn),
        .tx_start    (tx_start),
        .tx_frame    (tx_frame),
        .tx_len      (tx_len),
        .b_bus_out   (b_bus_out),
        .b_bus_drive (b_bus_drive),
        .tx_done     (tx_done)
    );

    bit_deserializer #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_deserializer (
        .clk        (clk),
        .rstn       (rstn),
        .rx_start   (rx_start),
        .b_bus_in   (b_bus_in),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid)
    );

endmodule

// ==== dv/bus_slave_model.sv ====
// --------------------
// behavioral slave for the serial bus master testbench
// grants the bus on request, holds the line high when idle,
// collects driven frames and answers them with ack patterns
// --------------------

module bus_slave_model
    import bus_master_pkg::*;
#(
    parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
    parameter int ADDR_WIDTH = DEFAULT_ADDR_WIDTH
)
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  b_request,
    input  logic                  b_rw,
    input  logic                  b_bus_out,
    input  logic                  b_bus_drive,
    input  logic                  withhold_ack,     // skip the next address ack
    input  logic                  block_grant,
    input  logic [DATA_WIDTH-1:0] read_byte,
    output logic                  b_grant,
    output logic                  b_bus_in,
    output logic [ADDR_WIDTH-1:0] frame_addr,
    output logic [DATA_WIDTH-1:0] frame_data,
    output int                    addr_frames,
    output int                    data_frames
);
    timeunit 1ns;
    timeprecision 1ns;

    logic [ADDR_WIDTH-1:0] shreg;
    int                    len;
    logic                  is_write;

    initial
    begin
        b_grant     = 1'b0;
        b_bus_in    = 1'b1;                       // pull-up
        addr_frames = 0;
        data_frames = 0;
        len         = 0;
    end

    task automatic put_bit(input logic value);
        @(posedge clk);
        #1 b_bus_in = value;
    endtask

    always @(posedge clk)
    begin
        #1 b_grant = rstn && b_request && !block_grant;
    end

    // bits are taken mid-cycle while the master drives the line
    always @(negedge clk)
    begin
        if (!rstn)
        begin
            len = 0;
        end
        else if (b_bus_drive)
        begin
            shreg = {shreg[ADDR_WIDTH-2:0], b_bus_out};
            len++;
        end
        else if (len != 0)
        begin
            if (len == ADDR_WIDTH)
            begin
                frame_addr = shreg;
                is_write   = b_rw;
                addr_frames++;
                if (!withhold_ack)
                begin
                    put_bit(1'b0);                // address ack 0,0
                    put_bit(1'b0);
                    put_bit(1'b1);
                    if (!is_write)
                    begin
                        put_bit(1'b0);            // read start 0,1
                        put_bit(1'b1);
                        for (int i = DATA_WIDTH - 1; i >= 0; i--)
                            put_bit(read_byte[i]);
                        put_bit(1'b1);
                    end
                end
            end
            else if (len == DATA_WIDTH)
            begin
                frame_data = shreg[DATA_WIDTH-1:0];
                data_frames++;
                put_bit(1'b0);                    // data ack 0,1
                put_bit(1'b1);
            end
            len = 0;
        end
    end

endmodule

// ==== dv/tb_bus_master.sv ====
// --------------------
// testbench for the serial bus master
// runs reset, request/release, write, read, address retry and
// a grant drop against a slave model and checks them with assertions
// --------------------

module tb_bus_master
    import bus_master_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ns;

    localparam int DW        = DEFAULT_DATA_WIDTH;
    localparam int AW        = DEFAULT_ADDR_WIDTH;
    localparam int HALF_TIME = 2 ** (DEFAULT_TIMEOUT_BITS - 1);
    localparam int LIMIT     = 200;

    logic clk, rstn, m_hold, m_execute, m_rw;
    logic [AW-1:0] m_address, frame_addr, first_addr;
    logic [DW-1:0] m_din, m_dout, read_byte, frame_data;
    logic m_dvalid, m_master_bsy, b_grant, b_bus_in, b_request, b_rw, b_busy;
    logic b_bus_out, b_bus_drive, withhold_ack, block_grant;
    int addr_frames, data_frames;
    int value_errors = 0;
    int protocol_errors = 0;

    bus_master_top uut (.*);

    bus_slave_model slave (.*);

    always #10 clk = ~clk;

    a_no_drive: assert property (@(posedge clk) disable iff (!rstn) !b_grant |-> !b_bus_drive)
    else
    begin
        protocol_errors++;
        $display("bus driven while grant is low");
    end

    a_no_busy: assert property (@(posedge clk) disable iff (!rstn) !b_grant |=> !b_busy)
    else
    begin
        protocol_errors++;
        $display("busy stayed high after grant was lost");
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            value_errors++;
            $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic wait_granted();
        int n;
        for (n = 0; n < LIMIT && !(b_busy && !m_master_bsy); n++)
            @(negedge clk);
        if (!(b_busy && !m_master_bsy))
            give_up("bus grant");
    endtask

    task automatic wait_request(input logic level, input int limit);
        int n;
        for (n = 0; n < limit && b_request !== level; n++)
            @(negedge clk);
        if (b_request !== level)
            give_up("b_request level");
    endtask

    task automatic wait_addr_frames(input int target);
        int n;
        for (n = 0; n < LIMIT && addr_frames < target; n++)
            @(negedge clk);
        if (addr_frames < target)
            give_up("address frame");
    endtask

    task automatic wait_dvalid_once();
        int n;
        for (n = 0; n < LIMIT && !m_dvalid; n++)
            @(negedge clk);
        if (!m_dvalid)
            give_up("m_dvalid");
    endtask

    task automatic pulse_execute(input logic rw, input logic [AW-1:0] addr,
                                 input logic [DW-1:0] din);
        @(posedge clk);
        #1;
        m_execute = 1'b1;
        m_rw      = rw;
        m_address = addr;
        m_din     = din;
        @(posedge clk);
        #1 m_execute = 1'b0;
    endtask

    // data frame, data ack and the completion strobe of a write
    task automatic finish_write(input logic [DW-1:0] din);
        int n;
        int target;
        target = data_frames + 1;
        for (n = 0; n < LIMIT && data_frames < target; n++)
            @(negedge clk);
        if (data_frames < target)
            give_up("write data frame");
        check_value("frame_data", 32'(frame_data), 32'(din));
        wait_dvalid_once();
        @(negedge clk);
        check_value("m_dvalid", 32'(m_dvalid), 32'h0);   // single pulse
    endtask

    task automatic do_write(input logic [AW-1:0] addr, input logic [DW-1:0] din);
        pulse_execute(1'b1, addr, din);
        wait_addr_frames(addr_frames + 1);
        check_value("frame_addr", 32'(frame_addr), 32'(addr));
        check_value("b_rw", 32'(b_rw), 32'h1);
        finish_write(din);
    endtask

    task automatic do_read(input logic [AW-1:0] addr, input logic [DW-1:0] value);
        read_byte = value;
        pulse_execute(1'b0, addr, '0);
        wait_addr_frames(addr_frames + 1);
        check_value("frame_addr", 32'(frame_addr), 32'(addr));
        check_value("b_rw", 32'(b_rw), 32'h0);
        wait_dvalid_once();
        check_value("m_dout", 32'(m_dout), 32'(value));
    endtask

    initial
    begin
        logic [AW-1:0] addr;
        logic [DW-1:0] data;
        int            start;
        clk = 0;
        rstn = 0;
        m_hold = 0;
        m_execute = 0;
        m_rw = 0;
        m_address = '0;
        m_din = '0;
        withhold_ack = 0;
        block_grant = 0;
        read_byte = '0;
        void'($urandom(30898));
        repeat (10)
        begin
            @(negedge clk);
            check_value("reset outputs", 32'({b_request, b_busy, b_bus_drive, m_dvalid,
                        m_master_bsy}), 32'h0);
        end
        @(posedge clk);
        #1 rstn = 1;
        @(negedge clk);
        check_value("reset outputs", 32'({b_request, b_busy, b_bus_drive, m_dvalid,
                    m_master_bsy}), 32'h0);

        @(posedge clk);
        #1 m_hold = 1;
        wait_request(1'b1, 4);
        check_value("m_master_bsy", 32'(m_master_bsy), 32'h1);
        wait_granted();

        do_write(AW'($urandom), DW'($urandom));
        wait_granted();
        do_read(AW'($urandom), DW'($urandom));
        wait_granted();

        // take the grant away while the master sits idle on the bus
        @(posedge clk);
        #1 block_grant = 1;
        repeat (5) @(negedge clk);
        pulse_execute(1'b1, '1, '1);                     // no frame may start without grant
        @(negedge clk);
        check_value("m_master_bsy", 32'(m_master_bsy), 32'h1);
        @(posedge clk);
        #1 block_grant = 0;
        wait_granted();

        // one address ack goes missing
        addr = AW'($urandom);
        data = DW'($urandom);
        withhold_ack = 1;
        start = addr_frames;
        pulse_execute(1'b1, addr, data);
        wait_addr_frames(start + 1);
        withhold_ack = 0;
        first_addr = frame_addr;
        wait_request(1'b0, HALF_TIME + 8);
        wait_request(1'b1, HALF_TIME + 8);
        wait_addr_frames(start + 2);
        check_value("retry frame_addr", 32'(frame_addr), 32'(first_addr));
        check_value("frame_addr", 32'(frame_addr), 32'(addr));
        finish_write(data);
        wait_granted();

        @(posedge clk);
        #1 m_hold = 0;
        wait_request(1'b0, 4);
        @(negedge clk);
        check_value("b_busy", 32'(b_busy), 32'h0);

        repeat (3) @(negedge clk);
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
common/bus_master_pkg.sv
design/bit_serializer.sv
design/bit_deserializer.sv
master_ctrl/master_sequencer.sv
design/bus_master_top.sv
dv/bus_slave_model.sv
dv/tb_bus_master.sv

// ==== master_ctrl/master_sequencer.sv ====
// --------------------
// bus master control FSM
// requests and holds the bus for the local module, sends the address,
// waits for the slave acknowledge, then writes or reads one data word
// a missing address ack releases the bus and retries later
// --------------------

module master_sequencer
    import bus_master_pkg::*;
#(
    parameter int DATA_WIDTH   = DEFAULT_DATA_WIDTH,
    parameter int ADDR_WIDTH   = DEFAULT_ADDR_WIDTH,
    parameter int TIMEOUT_BITS = DEFAULT_TIMEOUT_BITS
)
(
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            m_hold,
    input  logic                            m_execute,
    input  logic                            m_rw,
    input  logic [ADDR_WIDTH-1:0]           m_address,
    input  logic [DATA_WIDTH-1:0]           m_din,
    input  logic                            b_grant,
    input  logic                            b_bus_in,
    input  logic                            tx_done,
    input  logic                            rx_valid,
    input  logic [DATA_WIDTH-1:0]           rx_data,
    output logic [DATA_WIDTH-1:0]           m_dout,
    output logic                            m_dvalid,
    output logic                            m_master_bsy,
    output logic                            b_request,
    output logic                            b_rw,
    output logic                            b_busy,
    output logic                            tx_start,
    output logic [ADDR_WIDTH-1:0]           tx_frame,
    output logic [$clog2(ADDR_WIDTH+1)-1:0] tx_len,
    output logic                            rx_start
);

    localparam int LEN_W = $clog2(ADDR_WIDTH + 1);

    master_state_e           state;
    logic [ADDR_WIDTH-1:0]   addr_q;        // kept for a resend after timeout
    logic [DATA_WIDTH-1:0]   wdata_q;
    logic                    prev_bit;      // older half of the ack pattern
    logic [TIMEOUT_BITS-1:0] timeout_cnt;
    logic [1:0]              bus_pair;

    assign bus_pair = {prev_bit, b_bus_in};

    // data goes out left aligned in the address sized frame
    if (ADDR_WIDTH < DATA_WIDTH)
    begin : g_width_check
        $error("ADDR_WIDTH must not be smaller than DATA_WIDTH");
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state        <= IDLE;
            addr_q       <= '0;
            wdata_q      <= '0;
            m_dout       <= '0;
            m_dvalid     <= 1'b0;
            m_master_bsy <= 1'b0;
            b_request    <= 1'b0;
            b_rw         <= 1'b0;
            b_busy       <= 1'b0;
            tx_start     <= 1'b0;
            tx_frame     <= '0;
            tx_len       <= '0;
            rx_start     <= 1'b0;
            prev_bit     <= 1'b1;
            timeout_cnt  <= '0;
        end
        else
        begin
            tx_start <= 1'b0;                   // strobes last one cycle
            rx_start <= 1'b0;
            m_dvalid <= 1'b0;
            case (state)
                IDLE:
                begin
                    b_busy       <= 1'b0;
                    b_request    <= m_hold;
                    m_master_bsy <= m_hold;
                    if (m_hold)
                        state <= BUS_REQUESTED;
                end
                BUS_REQUESTED:
                begin
                    b_busy <= b_grant;
                    if (b_grant)
                    begin
                        m_master_bsy <= 1'b0;   // local side may now execute
                        state        <= BUS_GRANTED;
                    end
                end
                BUS_GRANTED:
                begin
                    if (!m_hold)
                    begin
                        b_request    <= 1'b0;
                        b_busy       <= 1'b0;
                        m_master_bsy <= 1'b0;
                        state        <= IDLE;
                    end
                    else if (!b_grant)
                    begin
                        b_busy       <= 1'b0;
                        m_master_bsy <= 1'b1;
                        state        <= BUS_REQUESTED;
                    end
                    else if (m_execute)
                    begin
                        addr_q       <= m_address;
                        wdata_q      <= m_din;
                        b_rw         <= m_rw;
                        m_master_bsy <= 1'b1;
                        tx_start     <= 1'b1;
                        tx_frame     <= m_address;
                        tx_len       <= LEN_W'(ADDR_WIDTH);
                        state        <= ADDRESS_SEND;
                    end
                end
                ADDRESS_SEND:
                begin
                    b_busy <= b_grant;
                    if (tx_done)
                    begin
                        prev_bit    <= 1'b1;
                        timeout_cnt <= '0;
                        state       <= ADDR_ACK_WAIT;
                    end
                end
                ADDR_ACK_WAIT:
                begin
                    timeout_cnt <= timeout_cnt + 1'b1;
                    if (timeout_cnt == '1)
                    begin
                        b_request <= 1'b1;      // ask for the bus again
                        state     <= ADDR_RETRY;
                    end
                    else if (timeout_cnt[TIMEOUT_BITS-1])
                    begin
                        b_request <= 1'b0;      // back off, let others use the bus
                        b_busy    <= 1'b0;
                    end
                    else
                    begin
                        b_busy   <= b_grant;
                        prev_bit <= b_bus_in;
                        if (bus_pair == ADDR_ACK_PATTERN)
                        begin
                            prev_bit <= 1'b1;
                            if (b_rw)
                            begin
                                tx_start                           <= 1'b1;
                                tx_frame                           <= '0;
                                tx_frame[ADDR_WIDTH-1-:DATA_WIDTH] <= wdata_q;
                                tx_len                             <= LEN_W'(DATA_WIDTH);
                                state                              <= WRITE_DATA;
                            end
                            else
                            begin
                                state <= READ_START_WAIT;
                            end
                        end
                    end
                end
                ADDR_RETRY:
                begin
                    b_busy      <= b_grant;
                    timeout_cnt <= '0;
                    if (b_grant)
                    begin
                        tx_start <= 1'b1;
                        tx_frame <= addr_q;
                        tx_len   <= LEN_W'(ADDR_WIDTH);
                        state    <= ADDRESS_SEND;
                    end
                end
                READ_START_WAIT:
                begin
                    b_busy   <= b_grant;
                    prev_bit <= b_grant ? b_bus_in : 1'b1;
                    if (b_grant && bus_pair == DATA_ACK_PATTERN)
                    begin
                        rx_start <= 1'b1;       // data bits follow right away
                        state    <= READ_DATA;
                    end
                end
                READ_DATA:
                begin
                    b_busy <= b_grant;
                    if (rx_valid)
                    begin
                        m_dout       <= rx_data;
                        m_dvalid     <= 1'b1;
                        m_master_bsy <= 1'b0;
                        state        <= BUS_GRANTED;
                    end
                end
                WRITE_DATA:
                begin
                    b_busy <= b_grant;
                    if (tx_done)
                    begin
                        prev_bit <= 1'b1;
                        state    <= DATA_ACK_WAIT;
                    end
                end
                DATA_ACK_WAIT:
                begin
                    b_busy   <= b_grant;
                    prev_bit <= b_grant ? b_bus_in : 1'b1;
                    if (b_grant && bus_pair == DATA_ACK_PATTERN)
                    begin
                        m_dvalid     <= 1'b1;
                        m_master_bsy <= 1'b0;
                        state        <= BUS_GRANTED;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ownership is only claimed on a grant seen at the previous edge
    a_busy_granted: assert property (@(posedge clk) disable iff (!rstn)
        b_busy |-> $past(b_grant));

    a_done_not_busy: assert property (@(posedge clk) disable iff (!rstn)
        !(m_dvalid && m_master_bsy));

endmodule
